//--- Makefile
TOP := tomasuloTb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) --Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- files.f
+incdir+logic
logic/tomasuloPkg.sv
logic/issueControl.sv
logic/tagRegFile.sv
logic/reservationStation.sv
logic/addUnit.sv
logic/mulUnit.sv
logic/commonDataBus.sv
logic/tomasuloCore.sv
testbench/tbClock.sv
testbench/tomasuloTb.sv

//--- logic/addUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_defines.svh"

module addUnit (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic                dispatchValid,
    input  wire tomasuloPkg::aluOp_e dispatchOp,
    input  wire logic [`DATA_W-1:0]  dispatchA,
    input  wire logic [`DATA_W-1:0]  dispatchB,
    input  wire tomasuloPkg::tag_t   dispatchTag,
    input  wire logic                grant,
    output logic                     accept,
    output logic                     resultValid,
    output logic [`DATA_W-1:0]       resultData,
    output tomasuloPkg::tag_t        resultTag
);
    import tomasuloPkg::*;

    // free when empty or being drained this cycle
    assign accept = !resultValid || grant;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
        end else if (dispatchValid) begin
            resultValid <= 1'b1;
        end else if (grant) begin
            resultValid <= 1'b0;
        end
    end

    // holding register, stays put until granted
    always_ff @(posedge clk) begin
        if (dispatchValid) begin
            resultData <= (dispatchOp == opSub) ? dispatchA - dispatchB : dispatchA + dispatchB;
            resultTag  <= dispatchTag;
        end
    end

endmodule

`default_nettype wire

//--- logic/commonDataBus.sv
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_defines.svh"

module commonDataBus (
    input  wire logic               addValid,
    input  wire logic [`DATA_W-1:0] addData,
    input  wire tomasuloPkg::tag_t  addTag,
    input  wire logic               mulValid,
    input  wire logic [`DATA_W-1:0] mulData,
    input  wire tomasuloPkg::tag_t  mulTag,
    output logic                    addGrant,
    output logic                    mulGrant,
    output logic                    cdbValid,
    output logic [`DATA_W-1:0]      cdbData,
    output tomasuloPkg::tag_t       cdbTag
);

    // multiplier first, it stalls a deeper pipe
    assign mulGrant = mulValid;
    assign addGrant = addValid && !mulValid;

    // --------------------
    // broadcast mux
    // --------------------
    assign cdbValid = addValid || mulValid;
    assign cdbData  = mulValid ? mulData : addData;
    assign cdbTag   = mulValid ? mulTag : addTag;

    // the two stations own separate tag halves
    always_comb begin
        assert (!(addValid && mulValid) || addTag.id != mulTag.id);
    end

endmodule

`default_nettype wire

//--- logic/issueControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_defines.svh"

module issueControl (
    input  wire logic                    clk,
    input  wire logic                    arstN,
    input  wire logic                    issueValid,
    input  wire tomasuloPkg::instrWord_u issueWord,
    input  wire logic                    addFull,
    input  wire logic                    mulFull,
    output logic                         issueReady,
    output logic                         illegalPulse,
    output logic                         addWrite,
    output logic                         mulWrite,
    output tomasuloPkg::aluOp_e          stationOp,
    output logic [`REG_AW-1:0]           srcA,
    output logic [`REG_AW-1:0]           srcB,
    output logic [`REG_AW-1:0]           destAddr,
    output logic                         destWrite,
    output logic [`DATA_W-1:0]           immValue,
    output logic                         useImm
);
    import tomasuloPkg::*;

    logic isRType;
    logic isAddi;
    logic legal;
    logic needMul;
    logic accept;

    // --------------------
    // decode
    // --------------------
    assign isRType = issueWord.rType.op == opSpecial;
    assign isAddi  = issueWord.iType.op == opAddi;

    always_comb begin
        legal     = isAddi;
        stationOp = opAdd;
        if (isRType) begin
            case (issueWord.rType.func)
                fnAdd: legal = 1'b1;
                fnSub: begin
                    legal     = 1'b1;
                    stationOp = opSub;
                end
                fnMul: begin
                    legal     = 1'b1;
                    stationOp = opMul;
                end
                default: legal = 1'b0;
            endcase
        end
    end

    // rs/rt sit in the same place in both views
    assign srcA     = issueWord.rType.rs;
    assign srcB     = issueWord.rType.rt;
    assign destAddr = isAddi ? issueWord.iType.rt : issueWord.rType.rd;
    assign useImm   = isAddi;
    // sign extended immediate
    assign immValue = {{(`DATA_W - 16){issueWord.iType.immd16[15]}}, issueWord.iType.immd16};

    // --------------------
    // stall and allocate
    // --------------------
    assign needMul = stationOp == opMul;

    // illegal words never stall, they just get eaten
    assign issueReady = !(legal && (needMul ? mulFull : addFull));
    assign accept     = issueValid && issueReady && legal;
    assign addWrite   = accept && !needMul;
    assign mulWrite   = accept && needMul;
    // r0 keeps no tag
    assign destWrite  = accept && (destAddr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            illegalPulse <= 1'b0;
        end else begin
            illegalPulse <= issueValid && !legal;
        end
    end

    // a station only fills up behind one of our own writes
    assert property (@(posedge clk) disable iff (!arstN) $rose(addFull) |-> $past(addWrite));
    assert property (@(posedge clk) disable iff (!arstN) $rose(mulFull) |-> $past(mulWrite));

endmodule

`default_nettype wire

//--- logic/mulUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_defines.svh"

module mulUnit (
    input  wire logic               clk,
    input  wire logic               arstN,
    input  wire logic               dispatchValid,
    input  wire logic [`DATA_W-1:0] dispatchA,
    input  wire logic [`DATA_W-1:0] dispatchB,
    input  wire tomasuloPkg::tag_t  dispatchTag,
    input  wire logic               grant,
    output logic                    accept,
    output logic                    resultValid,
    output logic [`DATA_W-1:0]      resultData,
    output tomasuloPkg::tag_t       resultTag
);
    import tomasuloPkg::*;

    localparam int LAST = `MUL_STAGES - 1;

    logic [`MUL_STAGES-1:0] stageValid;
    logic [`DATA_W-1:0]     stageData [`MUL_STAGES];
    tag_t                   stageTag  [`MUL_STAGES];
    logic                   stall;

    // whole pipe freezes behind an ungranted product
    assign stall  = stageValid[LAST] && !grant;
    assign accept = !stall;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageValid <= '0;
        end else if (!stall) begin
            stageValid <= {stageValid[LAST-1:0], dispatchValid};
        end
    end

    // low word of the product, then carried along
    always_ff @(posedge clk) begin
        if (!stall) begin
            stageData[0] <= dispatchA * dispatchB;
            stageTag[0]  <= dispatchTag;
            for (int i = 1; i < `MUL_STAGES; i++) begin
                stageData[i] <= stageData[i-1];
                stageTag[i]  <= stageTag[i-1];
            end
        end
    end

    assign resultValid = stageValid[LAST];
    assign resultData  = stageData[LAST];
    assign resultTag   = stageTag[LAST];

endmodule

`default_nettype wire

//--- logic/reservationStation.sv
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_defines.svh"

module reservationStation #(
    parameter int STATION_ID = 0
) (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic                write,
    input  wire tomasuloPkg::aluOp_e op,
    input  wire logic [`DATA_W-1:0]  aData,
    input  wire tomasuloPkg::tag_t   aTag,
    input  wire logic [`DATA_W-1:0]  bData,
    input  wire tomasuloPkg::tag_t   bTag,
    input  wire logic                cdbValid,
    input  wire tomasuloPkg::tag_t   cdbTag,
    input  wire logic [`DATA_W-1:0]  cdbData,
    input  wire logic                unitAccept,
    output logic                     full,
    output logic                     dispatchValid,
    output tomasuloPkg::aluOp_e      dispatchOp,
    output logic [`DATA_W-1:0]       dispatchA,
    output logic [`DATA_W-1:0]       dispatchB,
    output tomasuloPkg::tag_t        dispatchTag,
    output tomasuloPkg::tag_t        allocTag,
    output logic                     pending
);
    import tomasuloPkg::*;

    localparam int   IDX_W = `TAG_W - 1;
    localparam logic SID   = 1'(STATION_ID);

    // waiting: holds operands, not dispatched yet
    logic [`RS_DEPTH-1:0] waiting;
    // inFlight: in the unit, tag still live until broadcast
    logic [`RS_DEPTH-1:0] inFlight;
    aluOp_e               entOp   [`RS_DEPTH];
    logic [`DATA_W-1:0]   entA    [`RS_DEPTH];
    logic [`DATA_W-1:0]   entB    [`RS_DEPTH];
    tag_t                 entATag [`RS_DEPTH];
    tag_t                 entBTag [`RS_DEPTH];

    logic [`RS_DEPTH-1:0] ready;
    logic [IDX_W-1:0]     freeIdx;
    logic [IDX_W-1:0]     pickIdx;
    logic                 anyFree;
    logic                 anyReady;

    function automatic logic busHit(tag_t t);
        return cdbValid && t.valid && t.id == cdbTag.id;
    endfunction

    // --------------------
    // select
    // --------------------
    // walk downward so the lowest index wins
    always_comb begin
        anyFree  = 1'b0;
        freeIdx  = '0;
        anyReady = 1'b0;
        pickIdx  = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            ready[i] = waiting[i] && !entATag[i].valid && !entBTag[i].valid;
            if (!waiting[i] && !inFlight[i]) begin
                anyFree = 1'b1;
                freeIdx = IDX_W'(i);
            end
            if (ready[i]) begin
                anyReady = 1'b1;
                pickIdx  = IDX_W'(i);
            end
        end
    end

    assign full     = !anyFree;
    assign allocTag = '{valid: anyFree, id: {SID, freeIdx}};
    assign pending  = |waiting || |inFlight;

    assign dispatchValid = anyReady && unitAccept;
    assign dispatchOp    = entOp[pickIdx];
    assign dispatchA     = entA[pickIdx];
    assign dispatchB     = entB[pickIdx];
    assign dispatchTag   = '{valid: 1'b1, id: {SID, pickIdx}};

    // --------------------
    // entry state
    // --------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            waiting  <= '0;
            inFlight <= '0;
        end else begin
            // own result on the bus releases the tag
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (cdbValid && cdbTag.id == {SID, IDX_W'(i)}) begin
                    inFlight[i] <= 1'b0;
                end
            end
            if (dispatchValid) begin
                waiting[pickIdx]  <= 1'b0;
                inFlight[pickIdx] <= 1'b1;
            end
            if (write) begin
                waiting[freeIdx] <= 1'b1;
            end
        end
    end

    // operands and their snooping
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (waiting[i] && busHit(entATag[i])) begin
                entA[i]    <= cdbData;
                entATag[i] <= tag_t'(0);
            end
            if (waiting[i] && busHit(entBTag[i])) begin
                entB[i]    <= cdbData;
                entBTag[i] <= tag_t'(0);
            end
        end
        if (write) begin
            entOp[freeIdx]   <= op;
            entA[freeIdx]    <= aData;
            entATag[freeIdx] <= aTag;
            entB[freeIdx]    <= bData;
            entBTag[freeIdx] <= bTag;
        end
    end

    // issue side has to stall on full
    assert property (@(posedge clk) disable iff (!arstN) write |-> !full);

endmodule

`default_nettype wire

//--- logic/tagRegFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_defines.svh"

module tagRegFile (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic [`REG_AW-1:0]  srcA,
    input  wire logic [`REG_AW-1:0]  srcB,
    output logic [`DATA_W-1:0]       srcAData,
    output logic [`DATA_W-1:0]       srcBData,
    output tomasuloPkg::tag_t        srcATag,
    output tomasuloPkg::tag_t        srcBTag,
    input  wire logic [`REG_AW-1:0]  destAddr,
    input  wire logic                destWrite,
    input  wire tomasuloPkg::tag_t   destTag,
    input  wire logic                cdbValid,
    input  wire tomasuloPkg::tag_t   cdbTag,
    input  wire logic [`DATA_W-1:0]  cdbData,
    input  wire logic [`REG_AW-1:0]  readAddr,
    output logic [`DATA_W-1:0]       readData,
    output logic                     readBusy,
    output logic                     anyPending
);
    import tomasuloPkg::*;

    localparam int NREGS = 1 << `REG_AW;

    logic [`DATA_W-1:0] regValue [NREGS];
    tag_t               regTag   [NREGS];
    logic [NREGS-1:0]   tagValid;

    // --------------------
    // source reads
    // --------------------
    // a tag on the bus this cycle turns into its value
    always_comb begin
        srcAData = regValue[srcA];
        srcATag  = regTag[srcA];
        srcBData = regValue[srcB];
        srcBTag  = regTag[srcB];
        if (cdbValid && srcATag.valid && srcATag.id == cdbTag.id) begin
            srcAData = cdbData;
            srcATag  = tag_t'(0);
        end
        if (cdbValid && srcBTag.valid && srcBTag.id == cdbTag.id) begin
            srcBData = cdbData;
            srcBTag  = tag_t'(0);
        end
    end

    // host port, raw state
    assign readData = regValue[readAddr];
    assign readBusy = regTag[readAddr].valid;

    always_comb begin
        for (int i = 0; i < NREGS; i++) begin
            tagValid[i] = regTag[i].valid;
        end
    end
    assign anyPending = |tagValid;

    // --------------------
    // update
    // --------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NREGS; i++) begin
                regValue[i] <= '0;
                regTag[i]   <= tag_t'(0);
            end
        end else begin
            // loop skips r0 so it stays zero
            for (int i = 1; i < NREGS; i++) begin
                // only the latest writer clears the tag
                if (cdbValid && regTag[i].valid && regTag[i].id == cdbTag.id) begin
                    regValue[i] <= cdbData;
                    regTag[i]   <= tag_t'(0);
                end
                // rename wins over a same-cycle clear
                if (destWrite && destAddr == `REG_AW'(i)) begin
                    regTag[i] <= destTag;
                end
            end
        end
    end

    // control unit must never rename r0
    assert property (@(posedge clk) disable iff (!arstN) destWrite |-> destAddr != '0);

endmodule

`default_nettype wire

//--- logic/tomasuloCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_defines.svh"

module tomasuloCore (
    input  wire logic               clk,
    input  wire logic               arstN,
    input  wire logic               issueValid,
    input  wire logic [31:0]        issueWord,
    output logic                    issueReady,
    output logic                    illegalPulse,
    input  wire logic [`REG_AW-1:0] readAddr,
    output logic [`DATA_W-1:0]      readData,
    output logic                    readBusy,
    output logic                    busy
);
    import tomasuloPkg::*;

    // decode and rename
    logic [`REG_AW-1:0] srcA;
    logic [`REG_AW-1:0] srcB;
    logic [`REG_AW-1:0] destAddr;
    logic               addWrite;
    logic               mulWrite;
    logic               destWrite;
    logic               useImm;
    logic               addFull;
    logic               mulFull;
    aluOp_e             stationOp;
    logic [`DATA_W-1:0] immValue;
    logic [`DATA_W-1:0] srcAData;
    logic [`DATA_W-1:0] srcBData;
    logic [`DATA_W-1:0] opBData;
    tag_t               srcATag;
    tag_t               srcBTag;
    tag_t               opBTag;
    tag_t               destTag;
    tag_t               addAllocTag;
    tag_t               mulAllocTag;
    logic               addPending;
    logic               mulPending;
    logic               anyPending;

    // stations to units
    logic               addDispatch;
    logic               mulDispatch;
    aluOp_e             addOp;
    logic [`DATA_W-1:0] addA;
    logic [`DATA_W-1:0] addB;
    logic [`DATA_W-1:0] mulA;
    logic [`DATA_W-1:0] mulB;
    tag_t               addDispTag;
    tag_t               mulDispTag;
    logic               addAccept;
    logic               mulAccept;

    // units to bus, and the bus
    logic               addValid;
    logic               mulValid;
    logic               addGrant;
    logic               mulGrant;
    logic [`DATA_W-1:0] addData;
    logic [`DATA_W-1:0] mulData;
    tag_t               addTag;
    tag_t               mulTag;
    logic               cdbValid;
    logic [`DATA_W-1:0] cdbData;
    tag_t               cdbTag;

    // --------------------
    // issue
    // --------------------
    issueControl controlUnit (
        .clk, .arstN, .issueValid, .issueWord, .addFull, .mulFull,
        .issueReady, .illegalPulse, .addWrite, .mulWrite, .stationOp,
        .srcA, .srcB, .destAddr, .destWrite, .immValue, .useImm
    );

    tagRegFile regFile (
        .clk, .arstN, .srcA, .srcB, .srcAData, .srcBData, .srcATag, .srcBTag,
        .destAddr, .destWrite, .destTag, .cdbValid, .cdbTag, .cdbData,
        .readAddr, .readData, .readBusy, .anyPending
    );

    // new tag comes from whichever station takes the word
    assign destTag = mulWrite ? mulAllocTag : addAllocTag;
    // addi puts its immediate in the b slot, already ready
    assign opBData = useImm ? immValue : srcBData;
    assign opBTag  = useImm ? tag_t'(0) : srcBTag;

    // --------------------
    // stations and units
    // --------------------
    reservationStation #(.STATION_ID(0)) addStation (
        .clk, .arstN, .write(addWrite), .op(stationOp),
        .aData(srcAData), .aTag(srcATag), .bData(opBData), .bTag(opBTag),
        .cdbValid, .cdbTag, .cdbData, .unitAccept(addAccept), .full(addFull),
        .dispatchValid(addDispatch), .dispatchOp(addOp), .dispatchA(addA),
        .dispatchB(addB), .dispatchTag(addDispTag), .allocTag(addAllocTag),
        .pending(addPending)
    );

    // op field is always mul here, so left open
    reservationStation #(.STATION_ID(1)) mulStation (
        .clk, .arstN, .write(mulWrite), .op(stationOp),
        .aData(srcAData), .aTag(srcATag), .bData(opBData), .bTag(opBTag),
        .cdbValid, .cdbTag, .cdbData, .unitAccept(mulAccept), .full(mulFull),
        .dispatchValid(mulDispatch), .dispatchOp(), .dispatchA(mulA),
        .dispatchB(mulB), .dispatchTag(mulDispTag), .allocTag(mulAllocTag),
        .pending(mulPending)
    );

    addUnit adder (
        .clk, .arstN, .dispatchValid(addDispatch), .dispatchOp(addOp),
        .dispatchA(addA), .dispatchB(addB), .dispatchTag(addDispTag),
        .grant(addGrant), .accept(addAccept), .resultValid(addValid),
        .resultData(addData), .resultTag(addTag)
    );

    mulUnit multiplier (
        .clk, .arstN, .dispatchValid(mulDispatch), .dispatchA(mulA),
        .dispatchB(mulB), .dispatchTag(mulDispTag), .grant(mulGrant),
        .accept(mulAccept), .resultValid(mulValid), .resultData(mulData),
        .resultTag(mulTag)
    );

    commonDataBus bus (
        .addValid, .addData, .addTag, .mulValid, .mulData, .mulTag,
        .addGrant, .mulGrant, .cdbValid, .cdbData, .cdbTag
    );

    // station pending also covers work inside the units
    assign busy = addPending || mulPending || anyPending;

endmodule

`default_nettype wire

//--- logic/tomasuloPkg.sv
`default_nettype none
`include "tomasulo_defines.svh"

package tomasuloPkg;

    // opcode and function field values
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddi    = 6'h08;
    localparam logic [5:0] fnAdd     = 6'h20;
    localparam logic [5:0] fnSub     = 6'h22;
    localparam logic [5:0] fnMul     = 6'h18;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] func;
        } rType;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] immd16;
        } iType;
    } instrWord_u;

    typedef enum logic [1:0] {
        opAdd,
        opSub,
        opMul
    } aluOp_e;

    // producer of a pending value
    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] id;
    } tag_t;

endpackage

`default_nettype wire

//--- logic/tomasulo_defines.svh
`ifndef TOMASULO_DEFINES_SVH
`define TOMASULO_DEFINES_SVH

// datapath and register file
`define DATA_W 32
`define REG_AW 5

// entries per reservation station
`define RS_DEPTH 4

// product latency in cycles
`define MUL_STAGES 3

// msb picks the station, low bits the entry
`define TAG_W 3

`endif

//--- testbench/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arstN
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release just after an edge, clear of the flops
    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tomasuloTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_defines.svh"

module tomasuloTb;
    import tomasuloPkg::*;

    localparam int NUM_INSTR      = 400;
    localparam int BATCH_LEN      = 50;
    localparam int NUM_BATCHES    = NUM_INSTR / BATCH_LEN;
    localparam int BURST_LEN      = 12;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (`MUL_STAGES + 8) + 200;

    logic               clk;
    logic               arstN;
    logic               issueValid;
    logic [31:0]        issueWord;
    logic               issueReady;
    logic               illegalPulse;
    logic [`REG_AW-1:0] readAddr;
    logic [`DATA_W-1:0] readData;
    logic               readBusy;
    logic               busy;

    // in-order view of registers 0..7
    logic [31:0] model [8];
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          illegalSent;
    int          pulseCount;
    int          cycleCount;

    tbClock clockGen (.clk, .arstN);

    tomasuloCore dut0 (
        .clk, .arstN, .issueValid, .issueWord, .issueReady, .illegalPulse,
        .readAddr, .readData, .readBusy, .busy
    );

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // random word, regs 0..7, roughly 10% illegal
    task automatic buildWord(input logic forceMul, output instrWord_u w);
        logic [31:0] sel;
        logic [31:0] f;
        int unsigned pct;
        rng = xorshift32(rng);
        sel = rng;
        rng = xorshift32(rng);
        f   = rng;
        pct = sel % 100;
        if (forceMul) begin
            pct = 99;
        end
        w             = '0;
        w.rType.rs    = {2'b00, f[2:0]};
        w.rType.rt    = {2'b00, f[5:3]};
        w.rType.rd    = {2'b00, f[8:6]};
        w.rType.shamt = f[13:9];
        if (pct < 10) begin
            if (f[14]) begin
                // bad opcode
                w.rType.op = f[20:15];
                if (w.rType.op == opSpecial || w.rType.op == opAddi) begin
                    w.rType.op = 6'h2b;
                end
            end else begin
                // special op, bad function
                w.rType.op   = opSpecial;
                w.rType.func = f[26:21];
                if (w.rType.func == fnAdd || w.rType.func == fnSub ||
                    w.rType.func == fnMul) begin
                    w.rType.func = 6'h25;
                end
            end
        end else if (pct < 40) begin
            w.iType.op     = opAddi;
            w.iType.immd16 = f[31:16];
        end else if (pct < 60) begin
            w.rType.func = fnAdd;
        end else if (pct < 75) begin
            w.rType.func = fnSub;
        end else begin
            w.rType.func = fnMul;
        end
    endtask

    // sequential semantics of one accepted word
    task automatic applyModel(input instrWord_u w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [2:0]  dest;
        logic        legal;
        a     = model[w.rType.rs[2:0]];
        b     = model[w.rType.rt[2:0]];
        res   = '0;
        dest  = w.rType.rd[2:0];
        legal = 1'b1;
        if (w.iType.op == opAddi) begin
            res  = a + {{16{w.iType.immd16[15]}}, w.iType.immd16};
            dest = w.iType.rt[2:0];
        end else if (w.rType.op == opSpecial && w.rType.func == fnAdd) begin
            res = a + b;
        end else if (w.rType.op == opSpecial && w.rType.func == fnSub) begin
            res = a - b;
        end else if (w.rType.op == opSpecial && w.rType.func == fnMul) begin
            res = a * b;
        end else begin
            legal = 1'b0;
        end
        if (!legal) begin
            illegalSent++;
        end else if (dest != 3'd0) begin
            // r0 is hardwired
            model[dest] = res;
        end
    endtask

    // --------------------
    // drivers
    // --------------------
    // entered and left 1 ns after a rising edge
    task automatic issueOne(input instrWord_u w, output logic stalled);
        logic taken;
        taken      = 1'b0;
        stalled    = 1'b0;
        issueValid = 1'b1;
        issueWord  = w;
        while (!taken) begin
            @(negedge clk);
            compareValue("r0 during issue", 32'd0, readData);
            // ready is stable here, so the next edge takes the word
            if (issueReady) begin
                taken = 1'b1;
                applyModel(w);
            end else begin
                stalled = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        issueValid = 1'b0;
    endtask

    task automatic waitIdle();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic checkRegister(input string name, input int addr,
                                 input logic [31:0] expected);
        readAddr = `REG_AW'(addr);
        @(negedge clk);
        compareValue(name, expected, readData);
        compareValue({name, " busy"}, 32'd0, 32'(readBusy));
        @(posedge clk);
        #1;
    endtask

    // one pulse cycle per illegal word
    always @(negedge clk) begin
        if (arstN && illegalPulse) begin
            pulseCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d  errors: %0d", checks, errors + 1);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        instrWord_u w;
        logic       stalled;
        logic       inBurst;
        logic       burstStalled;
        issueValid   = 1'b0;
        issueWord    = '0;
        readAddr     = '0;
        rng          = 32'd57;
        errors       = 0;
        checks       = 0;
        illegalSent  = 0;
        pulseCount   = 0;
        cycleCount   = 0;
        burstStalled = 1'b0;
        for (int i = 0; i < 8; i++) begin
            model[i] = '0;
        end

        wait (arstN === 1'b1);
        @(posedge clk);
        #1;

        // state right after reset
        @(negedge clk);
        compareValue("reset busy", 32'd0, 32'(busy));
        compareValue("reset illegalPulse", 32'd0, 32'(illegalPulse));
        compareValue("reset issueReady", 32'd1, 32'(issueReady));
        @(posedge clk);
        #1;
        for (int i = 0; i < (1 << `REG_AW); i++) begin
            checkRegister($sformatf("reset r%0d", i), i, 32'd0);
        end

        // odd batches open with a mul burst
        for (int b = 0; b < NUM_BATCHES; b++) begin
            readAddr = '0;
            burstStalled = 1'b0;
            for (int n = 0; n < BATCH_LEN; n++) begin
                inBurst = (b % 2 == 1) && (n < BURST_LEN);
                buildWord(inBurst, w);
                issueOne(w, stalled);
                if (inBurst && stalled) begin
                    burstStalled = 1'b1;
                end
            end
            if (b % 2 == 1) begin
                checks++;
                if (!burstStalled) begin
                    errors++;
                    $display("issueReady never fell during the mul burst of batch %0d", b);
                end
            end
            waitIdle();
            compareValue($sformatf("batch %0d illegal pulses", b), 32'(illegalSent),
                         32'(pulseCount));
            for (int i = 0; i < 8; i++) begin
                checkRegister($sformatf("batch %0d r%0d", b, i), i, model[i]);
            end
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
